// ==== all.f ====
icache_pkg.sv
plru_tree.sv
tag_store.sv
data_bram.sv
refill_unit.sv
icache.sv
tb_clock_gen.sv
tb_icache.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

TOP = tb_icache

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache;

    localparam int clk_period = 10;
    localparam int reset_cycles = 16;
    localparam int num_random = 400;
    localparam int num_directed = 48;
    // up to three idle cycles before every beat
    localparam int worst_refill = icache_pkg::beats_per_line * 4 + 4;
    localparam int watchdog_limit =
        (reset_cycles + (num_random + num_directed) * (worst_refill + 4)) * clk_period + 1000;

    logic clk;
    logic resetn;
    logic ibus_req;
    icache_pkg::addr_t ibus_addr;
    logic ibus_addr_ok;
    logic ibus_data_ok;
    icache_pkg::word_t ibus_data;
    logic ibus_index;
    logic cbus_valid;
    icache_pkg::addr_t cbus_addr;
    logic cbus_okay;
    icache_pkg::beat_t cbus_rdata;
    logic cbus_last;

    int checks = 0;
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int err_mark = 0;
    int refill_count = 0;
    icache_pkg::addr_t last_line_addr = '0;

    // reference model of tag, valid and tree bits per set
    logic [icache_pkg::num_ways-1:0] model_valid [icache_pkg::num_sets];
    icache_pkg::tag_t model_tags [icache_pkg::num_sets][icache_pkg::num_ways];
    icache_pkg::select_t model_select [icache_pkg::num_sets];

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    icache u_icache (
        .clk          (clk),
        .resetn       (resetn),
        .ibus_req     (ibus_req),
        .ibus_addr    (ibus_addr),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_data_ok (ibus_data_ok),
        .ibus_data    (ibus_data),
        .ibus_index   (ibus_index),
        .cbus_valid   (cbus_valid),
        .cbus_addr    (cbus_addr),
        .cbus_okay    (cbus_okay),
        .cbus_rdata   (cbus_rdata),
        .cbus_last    (cbus_last)
    );

    // fixed mixing of the beat address
    function automatic icache_pkg::beat_t beat_value(input icache_pkg::addr_t a);
        return a ^ {a[12:0], a[31:13]} ^ 32'h9e37_79b9;
    endfunction

    function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
        icache_pkg::addr_t lo;
        lo = {a[31:3], 3'b000};
        return {beat_value(lo + 32'd4), beat_value(lo)};
    endfunction

    // root picks the pair and a lower node the way inside it
    function automatic icache_pkg::way_t plru_victim(input icache_pkg::select_t s);
        if (s[0]) begin
            return {1'b1, s[2]};
        end
        return {1'b0, s[1]};
    endfunction

    function automatic icache_pkg::select_t plru_touch(input icache_pkg::select_t s,
                                                       input icache_pkg::way_t w);
        icache_pkg::select_t n;
        n = s;
        n[0] = !w[1];
        n[1 + w[1]] = !w[0];
        return n;
    endfunction

    // predicts hit or miss and updates the model state
    task automatic model_access(input icache_pkg::addr_t a, output logic miss);
        icache_pkg::index_t idx;
        icache_pkg::tag_t tag;
        icache_pkg::way_t way;
        logic found;
        idx = a[9:6];
        tag = a[31:10];
        found = 1'b0;
        way = '0;
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (model_valid[idx][w] && model_tags[idx][w] == tag) begin
                found = 1'b1;
                way = icache_pkg::way_t'(w);
            end
        end
        if (!found) begin
            way = plru_victim(model_select[idx]);
            model_valid[idx][way] = 1'b1;
            model_tags[idx][way] = tag;
        end
        model_select[idx] = plru_touch(model_select[idx], way);
        miss = !found;
    endtask

    task automatic check_word(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t got,
                              input icache_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // starts right after a falling edge and returns on the falling edge of the response
    task automatic fetch(input icache_pkg::addr_t addr);
        logic exp_miss;
        logic was_miss;
        int refills_before;
        model_access(addr, exp_miss);
        refills_before = refill_count;
        ibus_req = 1'b1;
        ibus_addr = addr;
        #1;
        while (ibus_addr_ok !== 1'b1) begin
            @(negedge clk);
            // nothing was accepted in the cycle before
            check_flag("ibus_data_ok", ibus_data_ok, 1'b0);
            #1;
        end
        @(negedge clk);
        ibus_req = 1'b0;
        check_flag("ibus_data_ok", ibus_data_ok, 1'b1);
        check_word("ibus_data", ibus_data, expected_word(addr));
        check_flag("ibus_index", ibus_index, addr[2]);
        was_miss = (refill_count != refills_before);
        check_flag("refill_started", was_miss, exp_miss);
        if (was_miss) begin
            check_addr("cbus_addr", last_line_addr, {addr[31:6], 6'b000000});
        end
    endtask

    // memory side with one beat per okay and random gaps
    initial begin : memory_responder
        int beat;
        int gap;
        logic active;
        logic ended;
        cbus_okay = 1'b0;
        cbus_rdata = '0;
        cbus_last = 1'b0;
        beat = 0;
        gap = 0;
        active = 1'b0;
        ended = 1'b0;
        forever begin
            @(negedge clk);
            cbus_okay = 1'b0;
            cbus_last = 1'b0;
            if (ended && cbus_valid === 1'b1) begin
                errors++;
                $display("cbus_valid stayed high after the last beat of a line");
            end
            ended = 1'b0;
            if (active && cbus_valid !== 1'b1) begin
                errors++;
                $display("cbus_valid dropped before the last beat of a line");
                active = 1'b0;
            end
            if (cbus_valid === 1'b1) begin
                if (!active) begin
                    active = 1'b1;
                    beat = 0;
                    gap = $urandom % 4;
                    refill_count++;
                    last_line_addr = cbus_addr;
                end
                if (gap > 0) begin
                    gap--;
                end else begin
                    cbus_okay = 1'b1;
                    cbus_rdata = beat_value(last_line_addr + 32'(4 * beat));
                    cbus_last = (beat == icache_pkg::beats_per_line - 1);
                    beat++;
                    gap = $urandom % 4;
                    if (beat == icache_pkg::beats_per_line) begin
                        active = 1'b0;
                        ended = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_limit);
        $display("timeout: the run did not end within %0d time units", watchdog_limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        icache_pkg::addr_t a;
        resetn = 1'b1;
        // a fetch already waits while reset is held
        ibus_req = 1'b1;
        ibus_addr = 32'h0000_0104;
        void'($urandom(28));
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            model_valid[s] = '0;
            model_select[s] = '0;
        end

        repeat (reset_cycles) begin
            @(negedge clk);
            check_flag("ibus_addr_ok", ibus_addr_ok, 1'b0);
            check_flag("ibus_data_ok", ibus_data_ok, 1'b0);
            check_flag("cbus_valid", cbus_valid, 1'b0);
        end
        resetn = 1'b0;
        fetch(32'h0000_0104);
        end_test("reset");

        fetch(32'h0001_2358);
        // later word of the same line while the refill may still run
        fetch(32'h0001_237c);
        end_test("miss refill");

        for (int i = 0; i < 16; i++) begin
            fetch(32'h0001_2340 + 32'(4 * i));
        end
        end_test("hit data");

        // five tags into set 5 and then revisits
        for (int i = 0; i < 5; i++) begin
            fetch({22'(12'h300 + i), 4'd5, 6'h10});
        end
        for (int i = 0; i < 5; i++) begin
            fetch({22'(12'h300 + i), 4'd5, 6'h08});
        end
        for (int i = 4; i >= 0; i--) begin
            fetch({22'(12'h300 + i), 4'd5, 6'h20});
        end
        end_test("replacement");

        for (int i = 0; i < num_random; i++) begin
            a = {22'(16'h0a00 + ($urandom % 6)), 4'($urandom % 2), 3'($urandom % 8),
                 1'($urandom % 2), 2'b00};
            fetch(a);
            repeat ($urandom % 3) @(negedge clk);
        end
        end_test("random fetch mix");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 10 unit period
    localparam int half_period = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

module icache (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ibus_req,
    input  icache_pkg::addr_t ibus_addr,
    output logic              ibus_addr_ok,
    output logic              ibus_data_ok,
    output icache_pkg::word_t ibus_data,
    output logic              ibus_index,
    output logic              cbus_valid,
    output icache_pkg::addr_t cbus_addr,
    input  logic              cbus_okay,
    input  icache_pkg::beat_t cbus_rdata,
    input  logic              cbus_last
);

    // request address fields
    icache_pkg::tag_t req_tag;
    icache_pkg::index_t req_index;
    icache_pkg::offset_t req_offset;
    logic req_half;

    assign req_tag = ibus_addr[icache_pkg::tag_lsb +: icache_pkg::tag_bits];
    assign req_index = ibus_addr[icache_pkg::index_lsb +: icache_pkg::index_bits];
    assign req_offset = ibus_addr[icache_pkg::offset_lsb +: icache_pkg::offset_bits];
    assign req_half = ibus_addr[icache_pkg::half_bit];

    logic hit;
    icache_pkg::way_t hit_way;
    icache_pkg::way_t victim_way;

    logic busy;
    icache_pkg::index_t line_index;
    icache_pkg::way_t line_way;
    icache_pkg::ready_t word_ready;
    logic completing;
    icache_pkg::offset_t completing_offset;
    logic fill;
    icache_pkg::tag_t fill_tag;

    icache_pkg::byte_en_t wr_en;
    icache_pkg::mem_addr_t wr_addr;
    icache_pkg::word_t wr_data;
    icache_pkg::mem_addr_t rd_addr;
    icache_pkg::word_t rd_data;

    logic in_refill;
    logic word_done;
    logic word_ok;
    logic accept;
    logic miss_start;

    logic data_ok_q;
    logic index_q;
    logic bypass_q;
    icache_pkg::beat_t bypass_hi_q;

    tag_store u_tag_store (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_index (req_index),
        .lookup_tag   (req_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .touch        (accept),
        .touch_way    (hit_way),
        .fill         (fill),
        .fill_index   (req_index),
        .fill_way     (victim_way),
        .fill_tag     (fill_tag)
    );

    refill_unit u_refill_unit (
        .clk               (clk),
        .resetn            (resetn),
        .miss_start        (miss_start),
        .miss_addr         (ibus_addr),
        .miss_way          (victim_way),
        .busy              (busy),
        .line_index        (line_index),
        .line_way          (line_way),
        .word_ready        (word_ready),
        .completing        (completing),
        .completing_offset (completing_offset),
        .fill              (fill),
        .fill_tag          (fill_tag),
        .cbus_valid        (cbus_valid),
        .cbus_addr         (cbus_addr),
        .cbus_okay         (cbus_okay),
        .cbus_rdata        (cbus_rdata),
        .cbus_last         (cbus_last),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data)
    );

    // port 1 reads hits, port 2 belongs to the refill
    data_bram u_data_bram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    assign rd_addr = {hit_way, req_index, req_offset};

    // hit on the line being refilled needs its word
    assign in_refill = busy && (hit_way == line_way) && (req_index == line_index);
    assign word_done = completing && (completing_offset == req_offset);
    assign word_ok = word_ready[req_offset] || word_done;
    assign accept = ibus_req && hit && (!in_refill || word_ok);

    // one refill at a time, later misses wait
    assign miss_start = ibus_req && !hit && !busy;

    assign ibus_addr_ok = accept;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
            bypass_q <= 1'b0;
        end else begin
            data_ok_q <= accept;
            bypass_q <= accept && in_refill && word_done;
        end
    end

    // upper half lands in the BRAM at the same edge as the read
    always_ff @(posedge clk) begin
        index_q <= req_half;
        bypass_hi_q <= cbus_rdata;
    end

    assign ibus_data_ok = data_ok_q;
    assign ibus_index = index_q;
    assign ibus_data = bypass_q ?
        {bypass_hi_q, rd_data[icache_pkg::cbus_width-1:0]} : rd_data;

endmodule

`default_nettype wire

// ==== refill_unit.sv ====
`default_nettype none

module refill_unit (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  miss_start,
    input  icache_pkg::addr_t     miss_addr,
    input  icache_pkg::way_t      miss_way,
    output logic                  busy,
    output icache_pkg::index_t    line_index,
    output icache_pkg::way_t      line_way,
    output icache_pkg::ready_t    word_ready,
    output logic                  completing,
    output icache_pkg::offset_t   completing_offset,
    output logic                  fill,
    output icache_pkg::tag_t      fill_tag,
    output logic                  cbus_valid,
    output icache_pkg::addr_t     cbus_addr,
    input  logic                  cbus_okay,
    input  icache_pkg::beat_t     cbus_rdata,
    input  logic                  cbus_last,
    output icache_pkg::byte_en_t  wr_en,
    output icache_pkg::mem_addr_t wr_addr,
    output icache_pkg::word_t     wr_data
);

    icache_pkg::refill_state_t state_q;
    icache_pkg::count_t count_q;
    icache_pkg::addr_t line_addr_q;
    icache_pkg::way_t way_q;
    icache_pkg::ready_t ready_q;

    logic beat;
    logic upper;
    logic start;
    icache_pkg::offset_t beat_offset;

    assign busy = (state_q == icache_pkg::fetch);
    assign start = (state_q == icache_pkg::idle) && miss_start;
    assign beat = busy && cbus_okay;

    // low counter bit is the half, the rest is the word offset
    assign upper = count_q[0];
    assign beat_offset = count_q[icache_pkg::count_bits-1:1];

    // tag goes valid in the miss cycle itself
    assign fill = start;
    assign fill_tag = miss_addr[icache_pkg::tag_lsb +: icache_pkg::tag_bits];

    assign line_index = line_addr_q[icache_pkg::index_lsb +: icache_pkg::index_bits];
    assign line_way = way_q;
    assign word_ready = ready_q;
    assign completing = beat && upper;
    assign completing_offset = beat_offset;

    assign cbus_valid = busy;
    assign cbus_addr = line_addr_q;

    // beat copied into both halves, enables pick one
    assign wr_data = {(icache_pkg::word_width / icache_pkg::cbus_width){cbus_rdata}};
    assign wr_addr = {way_q, line_index, beat_offset};
    always_comb begin
        if (!beat) begin
            wr_en = '0;
        end else if (upper) begin
            wr_en = icache_pkg::upper_half_en;
        end else begin
            wr_en = icache_pkg::lower_half_en;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= icache_pkg::idle;
            count_q <= '0;
            ready_q <= '0;
        end else begin
            case (state_q)
                icache_pkg::idle: begin
                    if (miss_start) begin
                        state_q <= icache_pkg::fetch;
                        count_q <= '0;
                        ready_q <= '0;
                    end
                end
                icache_pkg::fetch: begin
                    if (cbus_okay) begin
                        count_q <= count_q + 1'b1;
                        if (upper) begin
                            ready_q[beat_offset] <= 1'b1;
                        end
                        // memory ends the line with last
                        if (cbus_last) begin
                            state_q <= icache_pkg::idle;
                        end
                    end
                end
                default: begin
                    state_q <= icache_pkg::idle;
                end
            endcase
        end
    end

    // line-aligned address and way of the refill
    always_ff @(posedge clk) begin
        if (start) begin
            line_addr_q <= {miss_addr[icache_pkg::addr_width-1:icache_pkg::index_lsb],
                            {icache_pkg::index_lsb{1'b0}}};
            way_q <= miss_way;
        end
    end

endmodule

`default_nettype wire

// ==== data_bram.sv ====
`default_nettype none

module data_bram (
    input  logic                  clk,
    input  icache_pkg::mem_addr_t rd_addr,
    output icache_pkg::word_t     rd_data,
    input  icache_pkg::byte_en_t  wr_en,
    input  icache_pkg::mem_addr_t wr_addr,
    input  icache_pkg::word_t     wr_data
);

    // one entry per way, set and word offset
    icache_pkg::word_t mem [2**icache_pkg::mem_addr_bits];

    // read-before-write on a shared address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < icache_pkg::word_bytes; b++) begin
            if (wr_en[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== tag_store.sv ====
`default_nettype none

module tag_store (
    input  logic                 clk,
    input  logic                 resetn,
    input  icache_pkg::index_t   lookup_index,
    input  icache_pkg::tag_t     lookup_tag,
    output logic                 hit,
    output icache_pkg::way_t     hit_way,
    output icache_pkg::way_t     victim_way,
    input  logic                 touch,
    input  icache_pkg::way_t     touch_way,
    input  logic                 fill,
    input  icache_pkg::index_t   fill_index,
    input  icache_pkg::way_t     fill_way,
    input  icache_pkg::tag_t     fill_tag
);

    logic [icache_pkg::num_ways-1:0] valid_q [icache_pkg::num_sets];
    icache_pkg::tag_t tags_q [icache_pkg::num_sets][icache_pkg::num_ways];
    icache_pkg::select_t select_q [icache_pkg::num_sets];

    logic [icache_pkg::num_ways-1:0] hit_bits;
    icache_pkg::select_t touch_select;
    icache_pkg::select_t fill_select;

    // associative compare across all ways of the set
    for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : g_cmp
        assign hit_bits[w] = valid_q[lookup_index][w] &&
            (tags_q[lookup_index][w] == lookup_tag);
    end

    assign hit = |hit_bits;

    // one-hot to binary
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (hit_bits[w]) begin
                hit_way = hit_way | icache_pkg::way_t'(w);
            end
        end
    end

    // victim and touch update for the looked-up set
    plru_tree u_plru_lookup (
        .select     (select_q[lookup_index]),
        .touch_way  (touch_way),
        .victim     (victim_way),
        .new_select (touch_select)
    );

    // a fill counts as an access to the filled way
    plru_tree u_plru_fill (
        .select     (select_q[fill_index]),
        .touch_way  (fill_way),
        .victim     (),
        .new_select (fill_select)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < icache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
                select_q[s] <= '0;
            end
        end else begin
            if (touch) begin
                select_q[lookup_index] <= touch_select;
            end
            // fill wins if both hit the same set
            if (fill) begin
                valid_q[fill_index][fill_way] <= 1'b1;
                select_q[fill_index] <= fill_select;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags_q[fill_index][fill_way] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== plru_tree.sv ====
`default_nettype none

module plru_tree (
    input  icache_pkg::select_t select,
    input  icache_pkg::way_t    touch_way,
    output icache_pkg::way_t    victim,
    output icache_pkg::select_t new_select
);

    // bit 0 is the root, 0 means the victim is in ways 0/1
    // bit 1 chooses between ways 0 and 1, bit 2 between ways 2 and 3
    always_comb begin
        if (select[0]) begin
            victim = {1'b1, select[2]};
        end else begin
            victim = {1'b0, select[1]};
        end
    end

    // point every node on the path away from the touched way
    always_comb begin
        new_select = select;
        new_select[0] = ~touch_way[1];
        if (touch_way[1]) begin
            new_select[2] = ~touch_way[0];
        end else begin
            new_select[1] = ~touch_way[0];
        end
    end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // address layout, msb first: tag, index, offset, align
    localparam int addr_width = 32;
    localparam int num_ways = 4;
    localparam int way_bits = 2;
    localparam int num_sets = 16;
    localparam int index_bits = 4;
    localparam int line_words = 8;
    localparam int offset_bits = 3;
    localparam int align_bits = 3;
    localparam int tag_bits = addr_width - index_bits - offset_bits - align_bits;
    localparam int word_width = 64;
    localparam int word_bytes = word_width / 8;
    localparam int cbus_width = 32;
    localparam int beats_per_line = 16;
    localparam int count_bits = $clog2(beats_per_line);
    localparam int mem_addr_bits = way_bits + index_bits + offset_bits;

    // field positions inside a byte address
    localparam int offset_lsb = align_bits;
    localparam int index_lsb = offset_lsb + offset_bits;
    localparam int tag_lsb = index_lsb + index_bits;
    // bit 2 picks the 32-bit half of a word
    localparam int half_bit = 2;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0] way_t;
    typedef logic [num_ways-2:0] select_t;
    typedef logic [word_width-1:0] word_t;
    typedef logic [cbus_width-1:0] beat_t;
    typedef logic [count_bits-1:0] count_t;
    typedef logic [mem_addr_bits-1:0] mem_addr_t;
    typedef logic [word_bytes-1:0] byte_en_t;
    typedef logic [line_words-1:0] ready_t;

    // byte enables for each half of a word
    localparam byte_en_t lower_half_en = {{(word_bytes / 2){1'b0}}, {(word_bytes / 2){1'b1}}};
    localparam byte_en_t upper_half_en = {{(word_bytes / 2){1'b1}}, {(word_bytes / 2){1'b0}}};

    typedef enum logic {
        idle,
        fetch
    } refill_state_t;

endpackage

`default_nettype wire
